// ==== hw/io_map_pkg.sv ====
/*
 * I/O map of the subsystem.
 * Bus widths, register addresses and interrupt line numbering.
 */
package io_map_pkg;

    // Bus word and byte address widths
    localparam int IO_DATA_W = 16;
    localparam int IO_ADDR_W = 16;   // Bus carries bits 15:1

    // Board outputs and interrupt lines
    localparam int NUM_LEDS = 8;
    localparam int NUM_IRQS = 8;

    // Locally served register
    localparam logic [IO_ADDR_W-1:0] LED_ADDR = 16'hfffe;

    // Interrupt controller, pending at bit 1 low and mask at bit 1 high
    localparam logic [IO_ADDR_W-1:0] IRQ_PEND_ADDR = 16'hfff4;
    localparam logic [IO_ADDR_W-1:0] IRQ_MASK_ADDR = 16'hfff6;

    // Interval timer
    localparam logic [IO_ADDR_W-1:0] TIMER_COUNT_ADDR = 16'h0040;
    localparam logic [IO_ADDR_W-1:0] TIMER_CTRL_ADDR = 16'h0042;

    // Timer owns line 0, lines 1 to 7 come from outside
    localparam int IRQ_TIMER = 0;

endpackage

// ==== hw/periph_regs_pkg.sv ====
/*
 * Register formats of the I/O peripherals.
 * Timer control word and the union used to decode a timer write.
 */
package periph_regs_pkg;

    // Control word has two live bits at the bottom
    localparam int TIMER_RSVD_W = io_map_pkg::IO_DATA_W - 2;

    typedef struct packed {
        logic [TIMER_RSVD_W-1:0] reserved;
        logic irq_enable;   // Pulse timer_intr on wrap
        logic enable;       // Count down every clock
    } timer_ctrl_s;

    // Same bus word, seen as a count or a control word
    typedef union packed {
        logic [io_map_pkg::IO_DATA_W-1:0] reload_count;
        timer_ctrl_s ctrl;
    } timer_word_u;

endpackage

// ==== hw/io_bridge.sv ====
/*
 * I/O bus bridge.
 * Registers a master request, decodes it into one-hot chip selects,
 * serves the LED register and unmapped addresses locally, and merges
 * the responder acks and data into a registered response.
 */
module io_bridge (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             io_access,
    input  logic [io_map_pkg::IO_ADDR_W-1:1] io_addr,
    input  logic                             io_wr_en,
    input  logic [io_map_pkg::IO_DATA_W-1:0] io_wdata,
    input  logic                             timer_ack,
    input  logic [io_map_pkg::IO_DATA_W-1:0] timer_rdata,
    input  logic                             irq_ack,
    input  logic [io_map_pkg::IO_DATA_W-1:0] irq_rdata,
    output logic                             io_ack,
    output logic [io_map_pkg::IO_DATA_W-1:0] io_rdata,
    output logic                             timer_cs,
    output logic                             irq_cs,
    output logic                             sel_hi,
    output logic                             bus_wr_en,
    output logic [io_map_pkg::IO_DATA_W-1:0] bus_wdata,
    output logic [io_map_pkg::NUM_LEDS-1:0]  leds
);
    import io_map_pkg::*;

    logic                 busy;
    logic                 start;
    logic                 timer_hit;
    logic                 irq_hit;
    logic                 led_hit;
    logic                 led_cs;
    logic                 dflt_cs;
    logic                 local_ack;
    logic [IO_DATA_W-1:0] local_rdata;
    logic                 merged_ack;
    logic [IO_DATA_W-1:0] merged_rdata;

    // New request only when nothing is in flight
    assign start = io_access & ~busy;

    // Both registers of a peripheral differ only in bit 1
    always_comb begin
        timer_hit = (io_addr == TIMER_COUNT_ADDR[IO_ADDR_W-1:1]) ||
                    (io_addr == TIMER_CTRL_ADDR[IO_ADDR_W-1:1]);
        irq_hit   = (io_addr == IRQ_PEND_ADDR[IO_ADDR_W-1:1]) ||
                    (io_addr == IRQ_MASK_ADDR[IO_ADDR_W-1:1]);
        led_hit   = io_addr == LED_ADDR[IO_ADDR_W-1:1];
    end

    // Request stage, selects live for one cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            timer_cs <= 1'b0;
            irq_cs   <= 1'b0;
            led_cs   <= 1'b0;
            dflt_cs  <= 1'b0;
        end else begin
            timer_cs <= start & timer_hit;
            irq_cs   <= start & irq_hit;
            led_cs   <= start & led_hit;
            dflt_cs  <= start & ~(timer_hit | irq_hit | led_hit);
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            sel_hi    <= io_addr[1];
            bus_wr_en <= io_wr_en;
            bus_wdata <= io_wdata;
        end
    end

    // Held from decode until the merged ack is captured
    always_ff @(posedge clk) begin
        if (rst)
            busy <= 1'b0;
        else if (start)
            busy <= 1'b1;
        else if (merged_ack)
            busy <= 1'b0;
    end

    // Local responder for the LED register and unmapped space
    always_ff @(posedge clk) begin
        if (rst) begin
            leds      <= '0;
            local_ack <= 1'b0;
        end else begin
            local_ack <= led_cs | dflt_cs;
            if (led_cs && bus_wr_en)
                leds <= bus_wdata[NUM_LEDS-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (led_cs && !bus_wr_en)
            local_rdata <= {{(IO_DATA_W - NUM_LEDS){1'b0}}, leds};
        else
            local_rdata <= '0;   // Unmapped reads return zero
    end

    // Responders drive zero when idle
    assign merged_ack   = timer_ack | irq_ack | local_ack;
    assign merged_rdata = timer_rdata | irq_rdata | local_rdata;

    // Response stage
    always_ff @(posedge clk) begin
        if (rst)
            io_ack <= 1'b0;
        else
            io_ack <= merged_ack;
    end

    always_ff @(posedge clk)
        io_rdata <= merged_rdata;

endmodule

// ==== hw/irq_controller.sv ====
/*
 * Interrupt controller.
 * Latches timer and external sources into a pending register with
 * write-one-to-clear, masks them and drives a registered intr.
 */
module irq_controller (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             irq_cs,
    input  logic                             sel_hi,
    input  logic                             bus_wr_en,
    input  logic [io_map_pkg::IO_DATA_W-1:0] bus_wdata,
    input  logic                             timer_intr,
    input  logic [io_map_pkg::NUM_IRQS-2:0]  ext_irq,
    output logic                             irq_ack,
    output logic [io_map_pkg::IO_DATA_W-1:0] irq_rdata,
    output logic                             intr
);
    import io_map_pkg::*;

    logic [NUM_IRQS-1:0] sources;
    logic [NUM_IRQS-1:0] pending;
    logic [NUM_IRQS-1:0] mask;
    logic [NUM_IRQS-1:0] clr;
    logic                reg_rd;

    always_comb begin
        sources = {ext_irq, 1'b0};
        sources[IRQ_TIMER] = timer_intr;
    end

    // Write-one-to-clear on the pending address
    assign clr    = (irq_cs && bus_wr_en && !sel_hi) ? bus_wdata[NUM_IRQS-1:0] : '0;
    assign reg_rd = irq_cs & ~bus_wr_en;

    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= '0;
            mask    <= '0;
            intr    <= 1'b0;
            irq_ack <= 1'b0;
        end else begin
            pending <= (pending & ~clr) | sources;   // Live source beats clear
            if (irq_cs && bus_wr_en && sel_hi)
                mask <= bus_wdata[NUM_IRQS-1:0];
            intr    <= |(pending & mask);
            irq_ack <= irq_cs;
        end
    end

    // Zero when not read so the bridge can OR it in
    always_ff @(posedge clk) begin
        if (reg_rd && sel_hi)
            irq_rdata <= {{(IO_DATA_W - NUM_IRQS){1'b0}}, mask};
        else if (reg_rd)
            irq_rdata <= {{(IO_DATA_W - NUM_IRQS){1'b0}}, pending};
        else
            irq_rdata <= '0;
    end

endmodule

// ==== hw/interval_timer.sv ====
/*
 * Interval timer.
 * Reloading down-counter with a count and a control register,
 * pulses timer_intr each time it wraps with irq_enable set.
 */
module interval_timer (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             timer_cs,
    input  logic                             sel_hi,
    input  logic                             bus_wr_en,
    input  logic [io_map_pkg::IO_DATA_W-1:0] bus_wdata,
    output logic                             timer_ack,
    output logic [io_map_pkg::IO_DATA_W-1:0] timer_rdata,
    output logic                             timer_intr
);
    import io_map_pkg::*;
    import periph_regs_pkg::*;

    timer_word_u          wr_word;
    timer_ctrl_s          ctrl;
    logic [IO_DATA_W-1:0] reload;
    logic [IO_DATA_W-1:0] count;
    logic                 wr_count;
    logic                 wr_ctrl;

    // Same bus word, decoded by which register is addressed
    assign wr_word  = bus_wdata;
    assign wr_count = timer_cs & bus_wr_en & ~sel_hi;
    assign wr_ctrl  = timer_cs & bus_wr_en & sel_hi;

    always_ff @(posedge clk) begin
        if (rst) begin
            ctrl       <= '0;
            reload     <= '0;
            count      <= '0;
            timer_intr <= 1'b0;
        end else begin
            timer_intr <= 1'b0;
            if (wr_count) begin
                reload <= wr_word.reload_count;
                count  <= wr_word.reload_count;   // Restart from the new value
            end else if (ctrl.enable) begin
                if (count == '0) begin
                    count      <= reload;
                    timer_intr <= ctrl.irq_enable;
                end else begin
                    count <= count - 1'b1;
                end
            end
            if (wr_ctrl) begin
                ctrl <= '{reserved: '0,
                          irq_enable: wr_word.ctrl.irq_enable,
                          enable: wr_word.ctrl.enable};
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst)
            timer_ack <= 1'b0;
        else
            timer_ack <= timer_cs;
    end

    // Live count or control word, zero otherwise
    always_ff @(posedge clk) begin
        if (timer_cs && !bus_wr_en)
            timer_rdata <= sel_hi ? ctrl : count;
        else
            timer_rdata <= '0;
    end

endmodule

// ==== hw/io_subsystem_top.sv ====
/*
 * I/O subsystem top level.
 * Bridge in front of the interval timer and interrupt controller.
 */
module io_subsystem_top (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             io_access,
    input  logic [io_map_pkg::IO_ADDR_W-1:1] io_addr,
    input  logic                             io_wr_en,
    input  logic [io_map_pkg::IO_DATA_W-1:0] io_wdata,
    input  logic [io_map_pkg::NUM_IRQS-2:0]  ext_irq,
    output logic                             io_ack,
    output logic [io_map_pkg::IO_DATA_W-1:0] io_rdata,
    output logic [io_map_pkg::NUM_LEDS-1:0]  leds,
    output logic                             intr
);
    import io_map_pkg::*;

    // Shared peripheral bus
    logic                 timer_cs;
    logic                 irq_cs;
    logic                 sel_hi;
    logic                 bus_wr_en;
    logic [IO_DATA_W-1:0] bus_wdata;

    // Responses, ORed in the bridge
    logic                 timer_ack;
    logic [IO_DATA_W-1:0] timer_rdata;
    logic                 irq_ack;
    logic [IO_DATA_W-1:0] irq_rdata;

    logic                 timer_intr;

    io_bridge i_io_bridge (
        .clk         (clk),
        .rst         (rst),
        .io_access   (io_access),
        .io_addr     (io_addr),
        .io_wr_en    (io_wr_en),
        .io_wdata    (io_wdata),
        .timer_ack   (timer_ack),
        .timer_rdata (timer_rdata),
        .irq_ack     (irq_ack),
        .irq_rdata   (irq_rdata),
        .io_ack      (io_ack),
        .io_rdata    (io_rdata),
        .timer_cs    (timer_cs),
        .irq_cs      (irq_cs),
        .sel_hi      (sel_hi),
        .bus_wr_en   (bus_wr_en),
        .bus_wdata   (bus_wdata),
        .leds        (leds)
    );

    interval_timer i_interval_timer (
        .clk         (clk),
        .rst         (rst),
        .timer_cs    (timer_cs),
        .sel_hi      (sel_hi),
        .bus_wr_en   (bus_wr_en),
        .bus_wdata   (bus_wdata),
        .timer_ack   (timer_ack),
        .timer_rdata (timer_rdata),
        .timer_intr  (timer_intr)
    );

    irq_controller i_irq_controller (
        .clk        (clk),
        .rst        (rst),
        .irq_cs     (irq_cs),
        .sel_hi     (sel_hi),
        .bus_wr_en  (bus_wr_en),
        .bus_wdata  (bus_wdata),
        .timer_intr (timer_intr),
        .ext_irq    (ext_irq),
        .irq_ack    (irq_ack),
        .irq_rdata  (irq_rdata),
        .intr       (intr)
    );

endmodule

// ==== verif/tb_io_subsystem.sv ====
/*
 * Testbench for the I/O subsystem.
 * Drives bus handshakes and interrupt sources, checks read data against
 * a register model, and checks handshake latency and the intr output.
 */
module tb_io_subsystem;
    timeunit 1ns;
    timeprecision 1ps;
    import io_map_pkg::*;
    import periph_regs_pkg::*;

    localparam int CLK_PERIOD    = 100;
    localparam int ACCESS_CYCLES = 3;   // Two-cycle latency plus the ack cycle
    localparam int ACK_TIMEOUT   = 8;
    localparam int MAX_RELOAD    = 19;
    localparam int TIMER_TESTS   = 1;
    localparam int LED_ITERS     = 8;
    localparam int UNMAP_ITERS   = 6;
    localparam int TREG_ITERS    = 4;
    localparam int EXT_ITERS     = 6;
    localparam int HS_ITERS      = 8;
    localparam int NUM_ACCESSES  = 2 * LED_ITERS + 2 * UNMAP_ITERS + 2 + 4 * TREG_ITERS + 7
                                   + 1 + 3 * EXT_ITERS + HS_ITERS;
    localparam int WATCHDOG_CYCLES = NUM_ACCESSES * ACCESS_CYCLES
                                     + 4 * MAX_RELOAD * TIMER_TESTS + 200;

    logic                 clk;
    logic                 rst;
    logic                 io_access;
    logic [IO_ADDR_W-1:1] io_addr;
    logic                 io_wr_en;
    logic [IO_DATA_W-1:0] io_wdata;
    logic [NUM_IRQS-2:0]  ext_irq;
    logic                 io_ack;
    logic [IO_DATA_W-1:0] io_rdata;
    logic [NUM_LEDS-1:0]  leds;
    logic                 intr;

    // Register model
    logic [NUM_LEDS-1:0]  m_leds;
    logic [NUM_IRQS-1:0]  m_pending;
    logic [NUM_IRQS-1:0]  m_mask;
    logic [IO_DATA_W-1:0] m_reload;
    timer_ctrl_s          m_ctrl;

    // Outstanding responses in issue order
    logic [IO_DATA_W-1:0] exp_q[$];
    bit                   chk_q[$];
    string                name_q[$];

    logic prev_ack = 1'b0;
    int   errors = 0;
    int   tests = 0;
    int   failed_tests = 0;
    int   test_start = 0;
    int   seed = 35598;

    io_subsystem_top i_io_subsystem_top (
        .clk       (clk),
        .rst       (rst),
        .io_access (io_access),
        .io_addr   (io_addr),
        .io_wr_en  (io_wr_en),
        .io_wdata  (io_wdata),
        .ext_irq   (ext_irq),
        .io_ack    (io_ack),
        .io_rdata  (io_rdata),
        .leds      (leds),
        .intr      (intr)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Expected read word for a byte address
    function automatic logic [IO_DATA_W-1:0] expected_read(input logic [IO_ADDR_W-1:0] addr);
        logic [IO_DATA_W-1:0] word;
        word = '0;
        if (addr == LED_ADDR)
            word[NUM_LEDS-1:0] = m_leds;
        else if (addr == IRQ_PEND_ADDR)
            word[NUM_IRQS-1:0] = m_pending;
        else if (addr == IRQ_MASK_ADDR)
            word[NUM_IRQS-1:0] = m_mask;
        else if (addr == TIMER_COUNT_ADDR)
            word = m_reload;   // Only read while the timer is stopped
        else if (addr == TIMER_CTRL_ADDR)
            word = m_ctrl;
        return word;
    endfunction

    task automatic model_write(input logic [IO_ADDR_W-1:0] addr, input logic [IO_DATA_W-1:0] data);
        if (addr == LED_ADDR)
            m_leds = data[NUM_LEDS-1:0];
        else if (addr == IRQ_PEND_ADDR)
            m_pending = m_pending & ~data[NUM_IRQS-1:0];
        else if (addr == IRQ_MASK_ADDR)
            m_mask = data[NUM_IRQS-1:0];
        else if (addr == TIMER_COUNT_ADDR)
            m_reload = data;
        else if (addr == TIMER_CTRL_ADDR) begin
            m_ctrl = '0;
            m_ctrl.irq_enable = data[1];
            m_ctrl.enable = data[0];
        end
    endtask

    function automatic bit is_mapped(input logic [IO_ADDR_W-1:0] addr);
        return addr[IO_ADDR_W-1:1] == LED_ADDR[IO_ADDR_W-1:1] ||
               addr[IO_ADDR_W-1:1] == IRQ_PEND_ADDR[IO_ADDR_W-1:1] ||
               addr[IO_ADDR_W-1:1] == IRQ_MASK_ADDR[IO_ADDR_W-1:1] ||
               addr[IO_ADDR_W-1:1] == TIMER_COUNT_ADDR[IO_ADDR_W-1:1] ||
               addr[IO_ADDR_W-1:1] == TIMER_CTRL_ADDR[IO_ADDR_W-1:1];
    endfunction

    task automatic check_word(input string name, input logic [IO_DATA_W-1:0] expected,
                              input logic [IO_DATA_W-1:0] actual);
        if (actual !== expected) begin
            $display("FAILED %s: expected %h, actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("FAILED %s: expected %b, actual %b", name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_latency(input string name, input int expected, input int actual);
        if (actual != expected) begin
            $display("FAILED %s: expected %0d cycles, actual %0d cycles", name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_leds(input string name);
        for (int i = 0; i < NUM_LEDS; i++)
            check_bit($sformatf("%s bit %0d", name, i), m_leds[i], leds[i]);
    endtask

    // One handshake that starts and ends on a falling edge
    task automatic bus_access(input string name, input logic [IO_ADDR_W-1:0] addr,
                              input logic wr, input logic [IO_DATA_W-1:0] wdata);
        int n;
        exp_q.push_back(expected_read(addr));
        chk_q.push_back(!wr);
        name_q.push_back(name);
        io_access = 1'b1;
        io_addr   = addr[IO_ADDR_W-1:1];
        io_wr_en  = wr;
        io_wdata  = wdata;
        n = 0;
        while (!io_ack && n < ACK_TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        io_access = 1'b0;
        io_wr_en  = 1'b0;
        if (!io_ack) begin
            $display("%s: no io_ack from the DUT within %0d cycles", name, ACK_TIMEOUT);
            errors++;
        end else begin
            check_latency(name, 2, n - 1);   // First edge samples the request
        end
        if (wr)
            model_write(addr, wdata);
        @(negedge clk);
    endtask

    task automatic end_test(input string name);
        tests++;
        if (errors == test_start) begin
            $display("%s: pass", name);
        end else begin
            failed_tests++;
            $display("%s: %0d errors", name, errors - test_start);
        end
        test_start = errors;
    endtask

    // Checks one ack per access
    always @(negedge clk) begin : compare_responses
        logic [IO_DATA_W-1:0] exp_word;
        bit                   do_check;
        string                resp_name;
        if (io_ack) begin
            if (prev_ack) begin
                $display("io_ack stayed high for more than one cycle");
                errors++;
            end else if (exp_q.size() == 0) begin
                $display("io_ack arrived with no access outstanding");
                errors++;
            end else begin
                exp_word  = exp_q.pop_front();
                do_check  = chk_q.pop_front();
                resp_name = name_q.pop_front();
                if (do_check)
                    check_word(resp_name, exp_word, io_rdata);
            end
        end
        prev_ack = io_ack;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Test failed");
        $finish;
    end

    initial begin
        logic [IO_DATA_W-1:0] data;
        logic [IO_ADDR_W-1:0] addr;
        logic [IO_ADDR_W-1:0] hs_addrs [5];
        logic [NUM_IRQS-1:0]  mask_w;
        logic [NUM_IRQS-1:0]  clear_w;
        logic [NUM_IRQS-2:0]  pattern;
        timer_ctrl_s          ctrl_w;
        int                   reload;
        int                   n;
        rst       = 1'b1;
        io_access = 1'b0;
        io_addr   = '0;
        io_wr_en  = 1'b0;
        io_wdata  = '0;
        ext_irq   = '0;
        m_leds    = '0;
        m_pending = '0;
        m_mask    = '0;
        m_reload  = '0;
        m_ctrl    = '0;
        hs_addrs  = '{LED_ADDR, IRQ_PEND_ADDR, IRQ_MASK_ADDR, TIMER_CTRL_ADDR, 16'h0100};
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);

        check_leds("led_reset");
        for (int i = 0; i < LED_ITERS; i++) begin
            data = 16'($random(seed));
            bus_access("led_write", LED_ADDR, 1'b1, data);
            check_leds("led_port");
            bus_access("led_read", LED_ADDR, 1'b0, '0);
        end
        end_test("led_register");

        for (int i = 0; i < UNMAP_ITERS; i++) begin
            do begin
                addr = 16'($random(seed));
            end while (is_mapped(addr));
            bus_access("unmapped_read", addr, 1'b0, '0);
            bus_access("unmapped_write", addr, 1'b1, 16'($random(seed)));
        end
        check_leds("unmapped_leds");
        bus_access("unmapped_led_read", LED_ADDR, 1'b0, '0);
        bus_access("unmapped_mask_read", IRQ_MASK_ADDR, 1'b0, '0);
        end_test("unmapped_space");

        for (int i = 0; i < TREG_ITERS; i++) begin
            data = 16'($random(seed));
            ctrl_w = '0;
            ctrl_w.irq_enable = 1'($random(seed));   // Counter stays stopped
            bus_access("timer_count_write", TIMER_COUNT_ADDR, 1'b1, data);
            bus_access("timer_ctrl_write", TIMER_CTRL_ADDR, 1'b1, ctrl_w);
            bus_access("timer_count_read", TIMER_COUNT_ADDR, 1'b0, '0);
            bus_access("timer_ctrl_read", TIMER_CTRL_ADDR, 1'b0, '0);
        end
        end_test("timer_registers");

        reload = 4 + ($random(seed) & 15);
        bus_access("timer_reload", TIMER_COUNT_ADDR, 1'b1, 16'(reload));
        bus_access("timer_mask", IRQ_MASK_ADDR, 1'b1, 16'h0001);
        ctrl_w = '0;
        ctrl_w.enable = 1'b1;
        ctrl_w.irq_enable = 1'b1;
        bus_access("timer_start", TIMER_CTRL_ADDR, 1'b1, ctrl_w);
        n = 0;
        while (!intr && n < reload + 8) begin
            @(negedge clk);
            n++;
        end
        // Enable lands at edge 1 and the wrap comes N+1 edges later
        check_latency("timer_intr_delay", reload + 1, n);
        check_bit("timer_intr_rise", 1'b1, intr);
        m_pending[IRQ_TIMER] = 1'b1;
        bus_access("timer_stop", TIMER_CTRL_ADDR, 1'b1, 16'h0000);
        bus_access("timer_pending_read", IRQ_PEND_ADDR, 1'b0, '0);
        bus_access("timer_pending_clear", IRQ_PEND_ADDR, 1'b1, 16'h0001);
        bus_access("timer_pending_cleared", IRQ_PEND_ADDR, 1'b0, '0);
        check_bit("timer_intr_fall", 1'b0, intr);
        end_test("timer_interrupt");

        mask_w = 8'($random(seed));
        bus_access("ext_mask_write", IRQ_MASK_ADDR, 1'b1, 16'(mask_w));
        for (int i = 0; i < EXT_ITERS; i++) begin
            pattern = 7'($random(seed));
            ext_irq = pattern;
            @(negedge clk);
            ext_irq = '0;
            m_pending = m_pending | {pattern, 1'b0};
            @(negedge clk);   // intr trails pending by a cycle
            check_bit("ext_intr_set", |(m_pending & m_mask), intr);
            bus_access("ext_pending_read", IRQ_PEND_ADDR, 1'b0, '0);
            clear_w = 8'($random(seed));
            bus_access("ext_pending_clear", IRQ_PEND_ADDR, 1'b1, 16'(clear_w));
            bus_access("ext_pending_after_clear", IRQ_PEND_ADDR, 1'b0, '0);
            check_bit("ext_intr_after_clear", |(m_pending & m_mask), intr);
        end
        end_test("external_interrupts");

        for (int i = 0; i < HS_ITERS; i++)
            bus_access("handshake_read", hs_addrs[($random(seed) & 32'h7fff) % 5], 1'b0, '0);
        end_test("handshake");

        $display("%0d tests, %0d failed, %0d errors", tests, failed_tests, errors);
        if (errors == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

// ==== filelist.f ====
hw/io_map_pkg.sv
hw/periph_regs_pkg.sv
hw/io_bridge.sv
hw/irq_controller.sv
hw/interval_timer.sv
hw/io_subsystem_top.sv
verif/tb_io_subsystem.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the I/O subsystem testbench with Verilator and runs it.
# Exit status is 0 only when the log holds the pass message.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=tb_io_subsystem

verilator --binary --timing -Wno-fatal -f filelist.f --top-module "$TOP" -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/V"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^Test passed$" "$LOG"; then
    exit 0
else
    echo "Pass message not found in $LOG"
    exit 1
fi
